// File: project.f
common/rx_pkg.sv
common/pcap_pkg.sv
hdl/rx_timestamp.sv
capture/byte_packer.sv
capture/frame_fifo.sv
hdl/pcap_framer.sv
hdl/rgmii_pcap.sv
bench/tb_rgmii_pcap.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_rgmii_pcap -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
exit 1

// File: bench/tb_rgmii_pcap.sv
module tb_rgmii_pcap import rx_pkg::*, pcap_pkg::*; ();

    typedef logic [7:0] byte_q_t [$];

    // Upper bounds of the bytes sent by each test
    localparam int TOTAL_BYTES = 61 + 64 + 6 * 128 + 3 * 400 + 2 * 50;
    localparam int MAX_CYCLES = 4 * TOTAL_BYTES + 2000;

    logic       axi_clk = 1'b0;
    logic       axi_rst;
    rx_beat_t   rx;
    ts_t        ts_gray;
    logic       enable;
    logic       m_ready = 1'b0;
    pcap_beat_t m_axis;
    logic       busy;
    logic       start_packet;
    logic       good_frame;
    logic       bad_frame;
    logic       overflow;

    logic [31:0] pay_lfsr = 32'hce6e;
    logic [31:0] rdy_lfsr = 32'hce6e;
    logic        ready_random;
    logic        ready_level;
    int          cycles = 0;
    int          err_count = 0;
    int          mon_errs = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;
    int          n_start = 0;
    int          n_good = 0;
    int          n_bad = 0;
    int          n_ovf = 0;
    int          n_busy = 0;
    int          got_idx = 0;
    pcap_beat_t  prev_beat;
    logic        prev_stall = 1'b0;

    // Expected output, consumed front first
    word_t exp_word [$];
    keep_t exp_keep [$];
    logic  exp_last [$];
    len_t  exp_len [$];

    // Every accepted output beat in arrival order
    word_t got_word [$];
    keep_t got_keep [$];
    logic  got_last [$];

    rgmii_pcap i_dut (
        .axi_clk      (axi_clk),
        .axi_rst      (axi_rst),
        .rx           (rx),
        .ts_gray      (ts_gray),
        .enable       (enable),
        .m_axis       (m_axis),
        .m_ready      (m_ready),
        .busy         (busy),
        .start_packet (start_packet),
        .good_frame   (good_frame),
        .bad_frame    (bad_frame),
        .overflow     (overflow)
    );

    always #50 axi_clk = ~axi_clk;

    always @(posedge axi_clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            pay_lfsr = lfsr_next(pay_lfsr);
            v = {v[6:0], pay_lfsr[0]};
        end
        return v;
    endfunction

    function automatic ts_t to_gray(input ts_t b);
        ts_t g;
        g.sec = b.sec ^ (b.sec >> 1);
        g.nsec = b.nsec ^ (b.nsec >> 1);
        return g;
    endfunction

    always @(posedge axi_clk) begin
        if (ready_random) begin
            rdy_lfsr <= lfsr_next(rdy_lfsr);
            m_ready <= rdy_lfsr[0];
        end else begin
            m_ready <= ready_level;
        end
    end

    // Outputs settle after the rising edge, so they are watched on the falling one
    always @(negedge axi_clk) begin
        if (!axi_rst) begin
            if (prev_stall && m_axis != prev_beat) begin
                $display("Output beat changed at t=%0t before m_ready took it", $time);
                mon_errs++;
            end
            prev_stall = m_axis.valid && !m_ready;
            prev_beat = m_axis;
            if (m_axis.valid && m_ready) begin
                got_word.push_back(m_axis.data);
                got_keep.push_back(m_axis.keep);
                got_last.push_back(m_axis.last);
            end
            if (start_packet) n_start++;
            if (good_frame) n_good++;
            if (bad_frame) n_bad++;
            if (overflow) n_ovf++;
            if (busy) n_busy++;
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_keep(input string name, input keep_t got, input keep_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_len(input string name, input len_t got, input len_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %0d exp %0d", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("%s happened %0d times instead of %0d", what, got, exp);
            err_count++;
        end
    endtask

    task automatic random_payload(input int n, output byte_q_t bytes);
        bytes = {};
        for (int i = 0; i < n; i++) begin
            bytes.push_back(rand_bits(8));
        end
    endtask

    // Header, length word, then byte k in word k/8 lane k%8
    task automatic expect_record(input byte_q_t bytes, input ts_t ts, input logic err);
        int    n;
        len_t  len;
        word_t data;
        keep_t keep;
        n = bytes.size();
        len = len_t'(n);
        exp_word.push_back({ts.sec, ts.nsec[31:1], err});
        exp_keep.push_back('1);
        exp_last.push_back(1'b0);
        exp_word.push_back({32'(len), 32'(len)});
        exp_keep.push_back('1);
        exp_last.push_back(1'b0);
        exp_len.push_back(len);
        for (int w = 0; w * 8 < n; w++) begin
            data = '0;
            keep = '0;
            for (int l = 0; l < WORD_BYTES; l++) begin
                if (w * 8 + l < n) begin
                    data[8*l +: 8] = bytes[w*8+l];
                    keep[l] = 1'b1;
                end
            end
            exp_word.push_back(data);
            exp_keep.push_back(keep);
            exp_last.push_back((w + 1) * 8 >= n);
        end
    endtask

    task automatic send_frame(input byte_q_t bytes, input ts_t ts, input int err_idx,
                              input logic en, output logic good, output logic ovf,
                              output logic bad);
        rx_beat_t beat;
        ts_t      cur;
        for (int i = 0; i < bytes.size(); i++) begin
            // Counter keeps running while the frame arrives
            cur = ts;
            cur.nsec = ts.nsec + 32'(i);
            beat.data = bytes[i];
            beat.valid = 1'b1;
            beat.last = (i == bytes.size() - 1);
            beat.error = (i == err_idx);
            @(posedge axi_clk);
            rx <= beat;
            ts_gray <= to_gray(cur);
            enable <= en;
        end
        @(posedge axi_clk);
        rx <= '0;
        // Status pulses come one cycle after the last beat
        @(negedge axi_clk);
        good = good_frame;
        ovf = overflow;
        bad = bad_frame;
        repeat (3) @(posedge axi_clk);
    endtask

    task automatic compare_output();
        int    pos;
        word_t mask;
        while (got_word.size() - got_idx < exp_word.size()) begin
            @(posedge axi_clk);
        end
        // Room for stray words to show up
        repeat (20) @(posedge axi_clk);
        check_count("Output word", got_word.size() - got_idx, exp_word.size());
        pos = 0;
        while (exp_word.size() > 0 && got_idx < got_word.size()) begin
            for (int l = 0; l < WORD_BYTES; l++) begin
                mask[8*l +: 8] = {8{exp_keep[0][l]}};
            end
            check_word("m_axis.data", got_word[got_idx] & mask, exp_word[0] & mask);
            check_keep("m_axis.keep", got_keep[got_idx], exp_keep[0]);
            check_flag("m_axis.last", got_last[got_idx], exp_last[0]);
            if (pos == 1) begin
                check_len("length", got_word[got_idx][LEN_W-1:0], exp_len.pop_front());
            end
            pos = exp_last[0] ? 0 : pos + 1;
            void'(exp_word.pop_front());
            void'(exp_keep.pop_front());
            void'(exp_last.pop_front());
            got_idx++;
        end
        exp_word.delete();
        exp_keep.delete();
        exp_last.delete();
        exp_len.delete();
        got_idx = got_word.size();
    endtask

    task automatic report_test(input string name, input int errs0);
        int errs;
        errs = err_count + mon_errs - errs0;
        if (errs == 0) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", name, errs);
            tests_bad++;
        end
    endtask

    task automatic clean_frame();
        byte_q_t bytes;
        ts_t     ts;
        logic    good;
        logic    ovf;
        logic    bad;
        int      errs0;
        int      start0;
        int      good0;
        int      busy0;
        errs0 = err_count + mon_errs;
        start0 = n_start;
        good0 = n_good;
        busy0 = n_busy;
        random_payload(61, bytes);
        // Odd nsec, so bit 0 must be replaced by the clear error flag
        ts.sec = 32'h6512_a0f3;
        ts.nsec = 32'h1d2c_4e57;
        expect_record(bytes, ts, 1'b0);
        send_frame(bytes, ts, -1, 1'b1, good, ovf, bad);
        check_flag("good_frame", good, 1'b1);
        check_flag("overflow", ovf, 1'b0);
        check_flag("bad_frame", bad, 1'b0);
        compare_output();
        check_count("good_frame pulse", n_good - good0, 1);
        check_count("start_packet pulse", n_start - start0, 1);
        // Busy covers the start beat through the last beat
        check_count("Busy cycle", n_busy - busy0, 61);
        report_test("clean frame", errs0);
    endtask

    task automatic error_frame();
        byte_q_t bytes;
        ts_t     ts;
        logic    good;
        logic    ovf;
        logic    bad;
        int      errs0;
        int      bad0;
        errs0 = err_count + mon_errs;
        bad0 = n_bad;
        random_payload(64, bytes);
        ts.sec = 32'h0000_1f40;
        ts.nsec = 32'h3b9a_c9fe;
        expect_record(bytes, ts, 1'b1);
        send_frame(bytes, ts, 30, 1'b1, good, ovf, bad);
        check_flag("good_frame", good, 1'b1);
        check_flag("bad_frame", bad, 1'b1);
        compare_output();
        check_count("bad_frame pulse", n_bad - bad0, 1);
        report_test("error frame", errs0);
    endtask

    task automatic random_frames();
        byte_q_t bytes;
        ts_t     ts;
        logic    good;
        logic    ovf;
        logic    bad;
        int      errs0;
        int      n;
        errs0 = err_count + mon_errs;
        ready_random <= 1'b1;
        for (int f = 0; f < 6; f++) begin
            n = 1 + int'(rand_bits(7));
            random_payload(n, bytes);
            ts.sec = 32'h5000_0000 + 32'(f);
            ts.nsec = 32'h0abc_0001 + 32'(f * 977);
            expect_record(bytes, ts, 1'b0);
            send_frame(bytes, ts, -1, 1'b1, good, ovf, bad);
            check_flag("good_frame", good, 1'b1);
        end
        compare_output();
        ready_random <= 1'b0;
        report_test("random frames", errs0);
    endtask

    task automatic overflow_frames();
        byte_q_t bytes;
        ts_t     ts;
        logic    good;
        logic    ovf;
        logic    bad;
        int      errs0;
        int      ovf0;
        int      kept;
        logic    seen;
        errs0 = err_count + mon_errs;
        ovf0 = n_ovf;
        kept = 0;
        seen = 1'b0;
        ready_level <= 1'b0;
        @(posedge axi_clk);
        for (int f = 0; f < 3; f++) begin
            random_payload(400, bytes);
            ts.sec = 32'h7000_0000 + 32'(f);
            ts.nsec = 32'h0000_0100 * 32'(f + 1);
            send_frame(bytes, ts, -1, 1'b1, good, ovf, bad);
            if (good) begin
                expect_record(bytes, ts, 1'b0);
                kept++;
            end
            if (ovf) begin
                seen = 1'b1;
                break;
            end
        end
        if (!seen) begin
            $display("No overflow pulse while the output was stalled");
            err_count++;
        end
        if (kept == 0) begin
            $display("No frame was committed before the overflow");
            err_count++;
        end
        check_count("overflow pulse", n_ovf - ovf0, 1);
        ready_level <= 1'b1;
        compare_output();
        report_test("overflow", errs0);
    endtask

    task automatic disabled_frame();
        byte_q_t bytes;
        ts_t     ts;
        logic    good;
        logic    ovf;
        logic    bad;
        int      errs0;
        int      start0;
        int      busy0;
        int      got0;
        errs0 = err_count + mon_errs;
        start0 = n_start;
        busy0 = n_busy;
        got0 = got_word.size();
        random_payload(50, bytes);
        ts.sec = 32'h0102_0304;
        ts.nsec = 32'h0506_0708;
        send_frame(bytes, ts, -1, 1'b0, good, ovf, bad);
        repeat (16) @(posedge axi_clk);
        check_flag("good_frame", good, 1'b0);
        check_count("start_packet pulse", n_start - start0, 0);
        check_count("Busy cycle", n_busy - busy0, 0);
        check_count("Output word", got_word.size() - got0, 0);
        random_payload(50, bytes);
        expect_record(bytes, ts, 1'b0);
        send_frame(bytes, ts, -1, 1'b1, good, ovf, bad);
        check_flag("good_frame", good, 1'b1);
        compare_output();
        report_test("disabled frame", errs0);
    endtask

    initial begin
        axi_rst = 1'b1;
        rx = '0;
        ts_gray = '0;
        enable = 1'b0;
        ready_random = 1'b0;
        ready_level = 1'b1;
        repeat (2) @(posedge axi_clk);
        axi_rst <= 1'b0;
        @(negedge axi_clk);
        check_flag("m_axis.valid", m_axis.valid, 1'b0);
        check_flag("busy", busy, 1'b0);
        @(posedge axi_clk);
        clean_frame();
        error_frame();
        random_frames();
        overflow_frames();
        disabled_frame();
        $display("tests passed %0d, failed %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && err_count + mon_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/rgmii_pcap.sv
module rgmii_pcap import rx_pkg::*, pcap_pkg::*; (
    input  logic       axi_clk,
    input  logic       axi_rst,
    input  rx_beat_t   rx,
    input  ts_t        ts_gray,
    input  logic       enable,
    output pcap_beat_t m_axis,
    input  logic       m_ready,
    output logic       busy,
    output logic       start_packet,
    output logic       good_frame,
    output logic       bad_frame,
    output logic       overflow
);

    hdr_word_u  hdr;
    logic       frame_start;
    pcap_beat_t word;
    len_t       len;
    pcap_beat_t rd_word;
    logic       rd_ready;
    meta_t      meta;
    logic       meta_valid;
    logic       meta_ready;

    // Frame tracking doubles as the busy indication
    rx_timestamp i_timestamp (
        .axi_clk     (axi_clk),
        .axi_rst     (axi_rst),
        .rx          (rx),
        .ts_gray     (ts_gray),
        .enable      (enable),
        .hdr         (hdr),
        .frame_open  (busy),
        .frame_start (frame_start)
    );

    byte_packer i_packer (
        .axi_clk    (axi_clk),
        .axi_rst    (axi_rst),
        .rx         (rx),
        .frame_open (busy),
        .word       (word),
        .len        (len)
    );

    frame_fifo i_fifo (
        .axi_clk      (axi_clk),
        .axi_rst      (axi_rst),
        .word         (word),
        .len          (len),
        .hdr          (hdr),
        .frame_start  (frame_start),
        .rd_word      (rd_word),
        .rd_ready     (rd_ready),
        .meta         (meta),
        .meta_valid   (meta_valid),
        .meta_ready   (meta_ready),
        .start_packet (start_packet),
        .good_frame   (good_frame),
        .bad_frame    (bad_frame),
        .overflow     (overflow)
    );

    pcap_framer i_framer (
        .axi_clk    (axi_clk),
        .axi_rst    (axi_rst),
        .meta       (meta),
        .meta_valid (meta_valid),
        .meta_ready (meta_ready),
        .rd_word    (rd_word),
        .rd_ready   (rd_ready),
        .m_axis     (m_axis),
        .m_ready    (m_ready)
    );

endmodule

// File: hdl/pcap_framer.sv
module pcap_framer import rx_pkg::*, pcap_pkg::*; (
    input  logic       axi_clk,
    input  logic       axi_rst,
    input  meta_t      meta,
    input  logic       meta_valid,
    output logic       meta_ready,
    input  pcap_beat_t rd_word,
    output logic       rd_ready,
    output pcap_beat_t m_axis,
    input  logic       m_ready
);

    // State names the word that sits in the output register
    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        LENGTH,
        PAYLOAD
    } state_t;

    state_t     state;
    pcap_beat_t out_q;
    len_t       len_q;
    logic       load;

    // Output register is free or empties this cycle
    assign load = !out_q.valid || m_ready;

    assign meta_ready = (state == IDLE) && load;
    assign rd_ready = (state == LENGTH || state == PAYLOAD) && load;
    assign m_axis = out_q;

    always_ff @(posedge axi_clk) begin
        if (axi_rst) begin
            state <= IDLE;
            out_q.valid <= 1'b0;
            out_q.last <= 1'b0;
        end else if (load) begin
            case (state)
                IDLE: begin
                    out_q.valid <= meta_valid;
                    out_q.last <= 1'b0;
                    if (meta_valid) begin
                        out_q.data <= meta.hdr.raw;
                        out_q.keep <= KEEP_ALL;
                        len_q <= meta.len;
                        state <= HEADER;
                    end
                end
                HEADER: begin
                    // Length in both halves of the second word
                    out_q.data <= {2{32'(len_q)}};
                    out_q.keep <= KEEP_ALL;
                    state <= LENGTH;
                end
                default: begin
                    out_q.data <= rd_word.data;
                    out_q.keep <= rd_word.keep;
                    out_q.valid <= rd_word.valid;
                    out_q.last <= rd_word.valid && rd_word.last;
                    if (rd_word.valid && rd_word.last) begin
                        state <= IDLE;
                    end else begin
                        state <= PAYLOAD;
                    end
                end
            endcase
        end
    end

endmodule

// File: capture/frame_fifo.sv
module frame_fifo import rx_pkg::*, pcap_pkg::*; (
    input  logic       axi_clk,
    input  logic       axi_rst,
    input  pcap_beat_t word,
    input  len_t       len,
    input  hdr_word_u  hdr,
    input  logic       frame_start,
    output pcap_beat_t rd_word,
    input  logic       rd_ready,
    output meta_t      meta,
    output logic       meta_valid,
    input  logic       meta_ready,
    output logic       start_packet,
    output logic       good_frame,
    output logic       bad_frame,
    output logic       overflow
);

    pcap_beat_t mem [FIFO_WORDS];
    meta_t      meta_mem [META_DEPTH];

    // wr_ptr runs ahead inside the open frame, wr_commit bounds the reader
    fifo_ptr_t wr_ptr;
    fifo_ptr_t wr_commit;
    fifo_ptr_t rd_ptr;
    fifo_ptr_t used;
    meta_ptr_t meta_wr;
    meta_ptr_t meta_rd;
    meta_ptr_t meta_used;

    logic      full;
    logic      meta_full;
    logic      dropping;
    logic      wr_en;
    logic      commit;
    logic      rd_en;
    logic      meta_rd_en;
    logic      start_q;
    hdr_word_u hdr_q;

    assign used = wr_ptr - rd_ptr;
    assign full = used == fifo_ptr_t'(FIFO_WORDS);
    assign meta_used = meta_wr - meta_rd;
    assign meta_full = meta_used == meta_ptr_t'(META_DEPTH);

    // The final word also needs a free slot in the metadata queue
    assign wr_en = word.valid && !dropping && !full && (!word.last || !meta_full);
    assign commit = wr_en && word.last;

    assign start_packet = start_q;
    assign good_frame = commit;
    assign overflow = word.valid && word.last && !commit;
    assign bad_frame = commit && hdr_q.ts.err;

    // Valid field is not taken from the RAM
    always_comb begin
        rd_word = mem[rd_ptr[FIFO_AW-1:0]];
        rd_word.valid = rd_ptr != wr_commit;
    end
    assign rd_en = rd_word.valid && rd_ready;

    assign meta = meta_mem[meta_rd[META_AW-1:0]];
    assign meta_valid = meta_used != '0;
    assign meta_rd_en = meta_valid && meta_ready;

    always_ff @(posedge axi_clk) begin
        if (axi_rst) begin
            wr_ptr <= '0;
            wr_commit <= '0;
            rd_ptr <= '0;
            meta_wr <= '0;
            meta_rd <= '0;
            dropping <= 1'b0;
            start_q <= 1'b0;
        end else begin
            start_q <= frame_start;
            if (word.valid) begin
                if (word.last) begin
                    dropping <= 1'b0;
                    if (commit) begin
                        wr_ptr <= wr_ptr + 1'b1;
                        wr_commit <= wr_ptr + 1'b1;
                        meta_wr <= meta_wr + 1'b1;
                    end else begin
                        // Roll back everything written for this frame
                        wr_ptr <= wr_commit;
                    end
                end else if (wr_en) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end else begin
                    dropping <= 1'b1;
                end
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (meta_rd_en) begin
                meta_rd <= meta_rd + 1'b1;
            end
        end
    end

    // Header is valid on the last beat, one cycle ahead of the final word
    always_ff @(posedge axi_clk) begin
        hdr_q <= hdr;
        if (wr_en) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= word;
        end
        if (commit) begin
            meta_mem[meta_wr[META_AW-1:0]] <= '{hdr: hdr_q, len: len};
        end
    end

endmodule

// File: capture/byte_packer.sv
module byte_packer import rx_pkg::*, pcap_pkg::*; (
    input  logic       axi_clk,
    input  logic       axi_rst,
    input  rx_beat_t   rx,
    input  logic       frame_open,
    output pcap_beat_t word,
    output len_t       len
);

    logic  take;
    logic  emit;
    lane_t lane;
    len_t  count;
    word_t shift_q;
    word_t shift_next;
    word_t data_q;
    keep_t keep_q;
    logic  valid_q;
    logic  last_q;
    len_t  len_q;

    // Only bytes of an accepted frame are packed
    assign take = rx.valid && frame_open;
    assign emit = take && (rx.last || lane == LAST_LANE);

    // New bytes enter at the top, so byte 0 ends in lane 0 of a full word
    assign shift_next = {rx.data, shift_q[$bits(word_t)-1:8]};

    always_ff @(posedge axi_clk) begin
        if (axi_rst) begin
            lane <= '0;
            count <= '0;
            valid_q <= 1'b0;
            last_q <= 1'b0;
        end else begin
            valid_q <= emit;
            last_q <= take && rx.last;
            if (take) begin
                lane <= rx.last ? '0 : lane + 1'b1;
                count <= rx.last ? '0 : count + 1'b1;
            end
        end
    end

    always_ff @(posedge axi_clk) begin
        if (take) begin
            shift_q <= shift_next;
        end
        if (emit) begin
            // Short last word is moved down to lane 0, upper lanes zero
            data_q <= shift_next >> {LAST_LANE - lane, 3'b000};
            keep_q <= KEEP_ALL >> (LAST_LANE - lane);
        end
        if (take && rx.last) begin
            len_q <= count + 1'b1;
        end
    end

    assign word.data = data_q;
    assign word.keep = keep_q;
    assign word.valid = valid_q;
    assign word.last = last_q;
    assign len = len_q;

endmodule

// File: hdl/rx_timestamp.sv
module rx_timestamp import rx_pkg::*, pcap_pkg::*; (
    input  logic      axi_clk,
    input  logic      axi_rst,
    input  rx_beat_t  rx,
    input  ts_t       ts_gray,
    input  logic      enable,
    output hdr_word_u hdr,
    output logic      frame_open,
    output logic      frame_start
);

    logic in_frame;
    logic accepted;
    logic start_beat;
    logic err_q;
    logic err_now;
    ts_t  ts_bin;
    ts_t  ts_q;

    assign ts_bin.sec = gray_to_bin(ts_gray.sec);
    assign ts_bin.nsec = gray_to_bin(ts_gray.nsec);

    // First valid beat while no frame is open
    assign start_beat = rx.valid && !in_frame;
    assign frame_start = start_beat && enable;

    // High from the start beat through the last beat of an accepted frame
    assign frame_open = frame_start || (in_frame && accepted);

    // Error flag over all beats so far, the current one included
    assign err_now = (err_q && !start_beat) || (rx.valid && rx.error);

    // A one-byte frame needs the live timestamp on its only beat
    always_comb begin
        hdr.ts.sec = start_beat ? ts_bin.sec : ts_q.sec;
        hdr.ts.nsec = start_beat ? ts_bin.nsec[31:1] : ts_q.nsec[31:1];
        hdr.ts.err = err_now;
    end

    always_ff @(posedge axi_clk) begin
        if (axi_rst) begin
            in_frame <= 1'b0;
            accepted <= 1'b0;
            err_q <= 1'b0;
        end else if (rx.valid) begin
            in_frame <= !rx.last;
            err_q <= err_now;
            if (start_beat) begin
                accepted <= enable;
            end
        end
    end

    always_ff @(posedge axi_clk) begin
        if (frame_start) begin
            ts_q <= ts_bin;
        end
    end

endmodule

// File: common/pcap_pkg.sv
package pcap_pkg;

    localparam int WORD_BYTES = 8;
    localparam int LANE_W = $clog2(WORD_BYTES);

    // Data FIFO capacity in words, 1024 bytes
    localparam int FIFO_WORDS = 128;
    localparam int FIFO_AW = $clog2(FIFO_WORDS);

    // Frames waiting for their header words
    localparam int META_DEPTH = 8;
    localparam int META_AW = $clog2(META_DEPTH);

    typedef logic [8*WORD_BYTES-1:0] word_t;
    typedef logic [WORD_BYTES-1:0] keep_t;
    typedef logic [LANE_W-1:0] lane_t;

    // Pointers carry one extra bit to tell full from empty
    typedef logic [FIFO_AW:0] fifo_ptr_t;
    typedef logic [META_AW:0] meta_ptr_t;

    localparam lane_t LAST_LANE = lane_t'(WORD_BYTES - 1);
    localparam keep_t KEEP_ALL = '1;

    typedef struct packed {
        word_t data;
        keep_t keep;
        logic  valid;
        logic  last;
    } pcap_beat_t;

    // Nanoseconds lose bit 0 to the receive error flag
    typedef struct packed {
        logic [31:0] sec;
        logic [31:1] nsec;
        logic        err;
    } hdr_ts_t;

    typedef union packed {
        word_t   raw;
        hdr_ts_t ts;
    } hdr_word_u;

    typedef struct packed {
        hdr_word_u   hdr;
        rx_pkg::len_t len;
    } meta_t;

endpackage

// File: common/rx_pkg.sv
package rx_pkg;

    // Frame length in bytes
    localparam int LEN_W = 16;

    typedef logic [LEN_W-1:0] len_t;

    // One byte from the receive MAC
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       last;
        logic       error;
    } rx_beat_t;

    // Seconds and nanoseconds, used both for gray and binary values
    typedef struct packed {
        logic [31:0] sec;
        logic [31:0] nsec;
    } ts_t;

    function automatic logic [31:0] gray_to_bin(input logic [31:0] gray);
        logic [31:0] bin;
        bin[31] = gray[31];
        for (int i = 30; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage
